// ==== pistorm_stimulus.txt ====
# rw(1=read) size(0=byte..3=long) addr wdata port_bytes berr expected as_cycles
# expected is read data right-aligned, or memory bytes big-endian after a write
0 3 001040 11223344 4 0 11223344 1
0 3 001051 a1b2c3d4 1 0 a1b2c3d4 4
0 1 001063 00005566 1 0 00005566 2
0 1 001071 0000beef 2 0 0000beef 2
1 0 00ab80 00000000 4 0 0000007f 1
1 0 00ab83 00000000 4 0 0000007c 1
1 0 00ab87 00000000 1 0 00000078 1
1 1 00ab91 00000000 4 0 00006e6d 1
1 1 00ab93 00000000 4 0 00006c6b 2
1 2 00aba2 00000000 2 0 005d5c5b 2
1 3 00abb1 00000000 2 0 4e4d4c4b 3
1 3 00abc2 00000000 1 0 3d3c3b3a 4
1 1 00abd3 00000000 2 0 00002c2b 2
1 3 00abe0 00000000 4 0 1f1e1d1c 1
1 2 00abf1 00000000 4 0 000e0d0c 1
1 3 00ab00 00000000 4 1 00000000 1

// ==== tb.f ====
pistorm_pkg.sv
bus_phase_gen.sv
pi_regs.sv
dyn_sizer.sv
bus_cycle_fsm.sv
pistorm_top.sv
tb_bus_slave.sv
tb_pistorm.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tb_pistorm
FILELIST  := tb.f
BIN       := obj_dir/V$(TOP)
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"

$(BIN): $(FILELIST) *.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

test: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "No pass message found"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_pistorm.sv ====
// ========================================
// Runs the accesses listed in pistorm_stimulus.txt.
// mc_clk is clk divided by 12, matching PLL_MULT.
// ========================================
module tb_pistorm;
    timeunit 1ns;
    timeprecision 100ps;

    logic                     clk = 1'b0;
    logic                     mc_clk = 1'b0;
    logic                     reset;
    pistorm_pkg::pi_reg_e     pi_a;
    pistorm_pkg::pi_word_u    pi_d_in;
    logic                     pi_wr, pi_rd;
    logic [15:0]              pi_d_out;
    logic                     pi_d_oe, pi_txn_in_progress;
    pistorm_pkg::mc_bus_out_t bus_out;
    pistorm_pkg::mc_bus_in_t  bus_in;
    pistorm_pkg::ctrl_lines_t ctrl;
    logic [2:0]               port_bytes;
    logic                     berr_en;
    logic [31:0]              as_count;
    int                       mc_div = 0;
    int                       err_word, err_status, err_ctrl;
    int                       seed = 63;
    logic                     prev_term;
    integer                   fd;
    integer                   code;
    logic [8*160-1:0]         line;
    logic [31:0]              f_rw, f_size, f_addr, f_wdata, f_pb, f_berr, f_exp, f_ncyc;

    pistorm_top #(.PLL_MULT(12)) i_dut (
        .clk(clk), .reset(reset), .mc_clk(mc_clk), .pi_a(pi_a), .pi_d_in(pi_d_in),
        .pi_wr(pi_wr), .pi_rd(pi_rd), .pi_d_out(pi_d_out), .pi_d_oe(pi_d_oe),
        .pi_txn_in_progress(pi_txn_in_progress), .bus_out(bus_out), .bus_in(bus_in),
        .ctrl(ctrl)
    );

    tb_bus_slave i_slave (
        .clk(clk), .reset(reset), .bus_out(bus_out), .port_bytes(port_bytes),
        .berr_en(berr_en), .bus_in(bus_in), .as_count(as_count)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        #2;
        if (mc_div == 5) begin  // Half of the 12 clk bus period.
            mc_div = 0;
            mc_clk = ~mc_clk;
        end else
            mc_div++;
    end

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            err_word++;
        end
    endtask

    task automatic check_status(input string name, input pistorm_pkg::pi_word_u got,
                                input pistorm_pkg::pi_word_u exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            err_status++;
        end
    endtask

    task automatic check_ctrl(input pistorm_pkg::ctrl_lines_t got,
                              input pistorm_pkg::ctrl_lines_t exp);
        if (got !== exp) begin
            $display("[ERROR] ctrl: got %h expected %h", got, exp);
            err_ctrl++;
        end
    endtask

    // Holds pi_a and data for 4 clk past the pi_wr fall.
    task automatic pi_write(input pistorm_pkg::pi_reg_e r, input logic [15:0] d);
        @(posedge clk);
        #2;
        pi_a    = r;
        pi_d_in = d;
        pi_wr   = 1'b0;
        @(negedge clk);
        check_word("pi_d_oe", {31'd0, pi_d_oe}, 32'd0);  // Pi data bus not driven.
        repeat (4) @(posedge clk);
        #2 pi_wr = 1'b1;
        repeat (2) @(posedge clk);
    endtask

    task automatic pi_read(input pistorm_pkg::pi_reg_e r, output logic [15:0] d);
        @(posedge clk);
        #2;
        pi_a  = r;
        pi_rd = 1'b0;
        @(negedge clk);
        d = pi_d_out;
        check_word("pi_d_oe", {31'd0, pi_d_oe}, 32'd1);
        @(posedge clk);
        #2 pi_rd = 1'b1;
    endtask

    task automatic wait_idle();
        for (int n = 0; n < 2000 && pi_txn_in_progress; n++)
            @(negedge clk);
        if (pi_txn_in_progress) begin
            $display("Timeout: bus access did not finish within 2000 cycles");
            $display("TESTBENCH FAILED");
            $finish;
        end
    endtask

    // Strobes and function code as the slave terminates the first bus cycle.
    task automatic verify_bus_strobes(input logic rw, input logic [2:0] fc);
        int n;
        for (n = 0; n < 2000; n++) begin
            @(negedge clk);
            if (bus_in.dsack_n != 2'b11 || !bus_in.berr_n)
                break;
        end
        if (bus_in.dsack_n == 2'b11 && bus_in.berr_n) begin
            $display("Timeout: the slave did not terminate a bus cycle within 2000 cycles");
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            check_word("bus_fc", {29'd0, bus_out.fc}, {29'd0, fc});
            check_word("bus_as_ds_oe", {29'd0, bus_out.as, bus_out.ds, bus_out.data_oe},
                       {29'd0, 2'b11, !rw});
        end
    endtask

    task automatic run_access(input logic rw, input pistorm_pkg::op_size_t size,
                              input logic [23:0] addr, input logic [31:0] wdata,
                              input logic [2:0] pb, input logic berr,
                              input logic [31:0] exp, input logic [31:0] ncyc);
        pistorm_pkg::pi_word_u hi_word;
        logic [15:0]           rd_lo, rd_hi;
        logic [31:0]           as_before, mem_word;
        port_bytes = pb;
        berr_en    = berr;
        hi_word.addr_hi = '{spare: 2'b00, fc: 3'd5, rw: rw, size: size, addr: addr[23:16]};
        pi_write(pistorm_pkg::REG_DATA_LO, wdata[15:0]);
        pi_write(pistorm_pkg::REG_DATA_HI, wdata[31:16]);
        pi_write(pistorm_pkg::REG_ADDR_LO, addr[15:0]);
        pi_read(pistorm_pkg::REG_DATA_LO, rd_lo);
        pi_read(pistorm_pkg::REG_DATA_HI, rd_hi);
        check_word("data_readback", {rd_hi, rd_lo}, wdata);
        pi_read(pistorm_pkg::REG_ADDR_LO, rd_lo);
        check_word("addr_lo", {16'h0, rd_lo}, {16'h0, addr[15:0]});
        as_before = as_count;
        pi_write(pistorm_pkg::REG_ADDR_HI, hi_word);
        pi_read(pistorm_pkg::REG_STATUS, rd_lo);
        check_status("status_busy", rd_lo, {14'd0, prev_term, 1'b1});
        check_word("txn_in_progress", {31'd0, pi_txn_in_progress}, 32'd1);
        pi_read(pistorm_pkg::REG_ADDR_HI, rd_hi);
        check_status("addr_hi", rd_hi, hi_word);
        verify_bus_strobes(rw, hi_word.addr_hi.fc);
        wait_idle();
        prev_term = !berr;
        pi_read(pistorm_pkg::REG_STATUS, rd_lo);
        check_status("status_done", rd_lo, {14'd0, !berr, 1'b0});
        check_word("as_count", as_count - as_before, ncyc);
        if (!berr) begin
            if (rw) begin
                pi_read(pistorm_pkg::REG_DATA_LO, rd_lo);
                pi_read(pistorm_pkg::REG_DATA_HI, rd_hi);
                check_word("read_data", {rd_hi, rd_lo}, exp);
            end else begin
                mem_word = 32'd0;
                for (int i = 0; i <= int'(size); i++)
                    mem_word = {mem_word[23:0], i_slave.mem[addr[7:0] + 8'(i)]};
                check_word("memory", mem_word, exp);
            end
        end
    endtask

    // Random set and clear masks against a model of the control register.
    task automatic exercise_ctrl();
        logic [14:0]           model;
        logic [31:0]           rnd;
        pistorm_pkg::pi_word_u w;
        model = 15'd0;
        for (int k = 0; k < 10; k++) begin
            rnd = $random(seed);
            w.control.set  = (k == 0) ? 1'b1 : (k == 9) ? 1'b0 : rnd[15];
            w.control.mask = (k == 0 || k == 9) ? 15'h001f : rnd[14:0];
            pi_write(pistorm_pkg::REG_STATUS, w);
            if (w.control.set)
                model = model | w.control.mask;
            else
                model = model & ~w.control.mask;
            check_ctrl(ctrl, model[4:0]);
        end
    endtask

    initial begin
        pi_a       = pistorm_pkg::REG_DATA_LO;
        pi_d_in    = 16'h0000;
        pi_wr      = 1'b1;
        pi_rd      = 1'b1;
        reset      = 1'b1;
        port_bytes = 3'd4;
        berr_en    = 1'b0;
        prev_term  = 1'b0;
        err_word   = 0;
        err_status = 0;
        err_ctrl   = 0;
        repeat (10) @(posedge clk);
        #2 reset = 1'b0;
        check_ctrl(ctrl, 5'd0);
        exercise_ctrl();
        fd = $fopen("pistorm_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file pistorm_stimulus.txt");
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code != 0)
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h", f_rw, f_size, f_addr,
                                   f_wdata, f_pb, f_berr, f_exp, f_ncyc);
                if (code == 8)  // Comment and blank lines give fewer fields.
                    run_access(f_rw[0], f_size[1:0], f_addr[23:0], f_wdata, f_pb[2:0],
                               f_berr[0], f_exp, f_ncyc);
            end
            $fclose(fd);
            $display("Errors: word=%0d status=%0d ctrl=%0d", err_word, err_status, err_ctrl);
            if (err_word + err_status + err_ctrl == 0)
                $display("TESTBENCH PASSED");
            else
                $display("TESTBENCH FAILED");
            $finish;
        end
    end

endmodule

// ==== tb_bus_slave.sv ====
// ========================================
// 68020 slave with a 256-byte memory on address bits 7:0.
// Terminates one bus clock (12 clk) after AS.
// ========================================
module tb_bus_slave (
    input  logic                     clk,
    input  logic                     reset,
    input  pistorm_pkg::mc_bus_out_t bus_out,
    input  logic [2:0]               port_bytes,  // 1, 2 or 4.
    input  logic                     berr_en,
    output pistorm_pkg::mc_bus_in_t  bus_in,
    output logic [31:0]              as_count
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] mem [0:255];
    logic       as_q;
    int         wait_cnt;
    int         width;
    int         offs;
    int         nbytes;
    logic [7:0] base;

    initial begin
        for (int i = 0; i < 256; i++)
            mem[i] = ~8'(i);  // Fill follows the address.
        bus_in   = '{data: 32'h0, dsack_n: 2'b11, berr_n: 1'b1};
        as_q     = 1'b0;
        as_count = 32'd0;
        wait_cnt = 13;
    end

    always @(posedge clk) begin
        #2;
        if (reset) begin
            bus_in.dsack_n = 2'b11;
            bus_in.berr_n  = 1'b1;
            as_q           = 1'b0;
            as_count       = 32'd0;
        end else begin
            if (bus_out.as && !as_q) begin
                as_count = as_count + 32'd1;
                wait_cnt = 0;
            end
            as_q = bus_out.as;
            width  = int'(port_bytes);
            offs   = int'(bus_out.addr[1:0]) & (width - 1);
            nbytes = (bus_out.size == 2'b00) ? 4 : int'(bus_out.size);
            base   = bus_out.addr[7:0] & ~8'(width - 1);
            if (!bus_out.as) begin
                bus_in.dsack_n = 2'b11;
                bus_in.berr_n  = 1'b1;
            end else if (wait_cnt == 12) begin
                if (berr_en)
                    bus_in.berr_n = 1'b0;
                else begin
                    bus_in.dsack_n = (width == 1) ? 2'b10 : (width == 2) ? 2'b01 : 2'b00;
                    if (bus_out.rw) begin
                        for (int l = 0; l < 4; l++)
                            bus_in.data[8*(3-l) +: 8] = mem[base + 8'(l)];
                    end else begin
                        for (int i = 0; i < nbytes && offs + i < width; i++)
                            mem[bus_out.addr[7:0] + 8'(i)] = bus_out.data[8*(3-offs-i) +: 8];
                    end
                end
            end
            if (wait_cnt < 13)
                wait_cnt++;
        end
    end

endmodule

// ==== pistorm_top.sv ====
// ========================================
// Pi to MC68EC020 bridge top level.
// clk runs at PLL_MULT times mc_clk.
// ========================================
module pistorm_top #(
    parameter int PLL_MULT = 12
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     mc_clk,
    input  pistorm_pkg::pi_reg_e     pi_a,
    input  pistorm_pkg::pi_word_u    pi_d_in,
    input  logic                     pi_wr,
    input  logic                     pi_rd,
    output logic [15:0]              pi_d_out,
    output logic                     pi_d_oe,
    output logic                     pi_txn_in_progress,
    output pistorm_pkg::mc_bus_out_t bus_out,
    input  pistorm_pkg::mc_bus_in_t  bus_in,
    output pistorm_pkg::ctrl_lines_t ctrl
);

    pistorm_pkg::phase_t         phase;
    pistorm_pkg::access_req_t    req;
    pistorm_pkg::access_result_t result;
    logic                        req_valid;

    assign pi_txn_in_progress = req_valid;

    bus_phase_gen #(.PLL_MULT(PLL_MULT)) i_phase (
        .clk(clk), .reset(reset), .mc_clk(mc_clk), .phase(phase)
    );

    pi_regs i_regs (
        .clk(clk), .reset(reset), .pi_a(pi_a), .pi_d_in(pi_d_in), .pi_wr(pi_wr),
        .pi_rd(pi_rd), .result(result), .pi_d_out(pi_d_out), .pi_d_oe(pi_d_oe),
        .req(req), .req_valid(req_valid), .ctrl(ctrl)
    );

    bus_cycle_fsm i_fsm (
        .clk(clk), .reset(reset), .phase(phase), .req(req), .req_valid(req_valid),
        .bus_in(bus_in), .bus_out(bus_out), .result(result)
    );

endmodule

// ==== bus_cycle_fsm.sv ====
// ========================================
// Assumes the bridge owns the bus at all times.
// A long operand may take up to four bus cycles.
// ========================================
module bus_cycle_fsm (
    input  logic                        clk,
    input  logic                        reset,
    input  pistorm_pkg::phase_t         phase,
    input  pistorm_pkg::access_req_t    req,
    input  logic                        req_valid,
    input  pistorm_pkg::mc_bus_in_t     bus_in,
    output pistorm_pkg::mc_bus_out_t    bus_out,
    output pistorm_pkg::access_result_t result
);

    typedef enum logic [2:0] {
        S_IDLE, S_START, S_ASSERT_AS, S_OPEN_DATA,
        S_WAIT_TERM, S_LATCH_DATA, S_UPDATE_READ, S_FINISH
    } state_e;

    state_e                   state;
    logic                     req_taken;
    logic [2:0]               fc;
    logic [23:0]              addr;
    pistorm_pkg::op_size_t    size;
    logic                     rw;
    logic [31:0]              wdata;
    logic [31:0]              rdata;
    logic                     term_q;
    logic                     done;
    logic [31:0]              bus_data_q;
    logic [1:0]               dsack_n_q;
    logic                     berr_n_q;
    pistorm_pkg::port_width_t width;
    logic [31:0]              lane_data;
    logic [31:0]              read_merged;
    pistorm_pkg::op_size_t    transferred;
    logic                     any_term;
    logic [2:0]               mc_fc;
    logic [23:0]              mc_addr;
    logic [1:0]               mc_size;
    logic                     mc_rw, mc_as, mc_ds, mc_data_oe;
    logic [31:0]              mc_data;

    always_comb begin
        case (dsack_n_q)
            2'b10: width = pistorm_pkg::PW_8;
            2'b01: width = pistorm_pkg::PW_16;
            default: width = pistorm_pkg::PW_32;
        endcase
    end

    assign any_term = ~&{dsack_n_q, berr_n_q};

    dyn_sizer i_sizer (
        .addr_lo(addr[1:0]), .size(size), .width(width), .write_data(wdata),
        .bus_data(bus_data_q), .read_partial(rdata), .lane_data(lane_data),
        .read_merged(read_merged), .transferred(transferred)
    );

    always_ff @(posedge clk) begin
        if (phase.falling)
            bus_data_q <= bus_in.data;
        if (reset) begin
            state <= S_IDLE;
            req_taken <= 1'b0;
            {mc_as, mc_ds, mc_data_oe, done, term_q} <= '0;
            dsack_n_q <= 2'b11;
            berr_n_q <= 1'b1;
        end else begin
            done <= 1'b0;
            if (phase.falling) begin
                dsack_n_q <= bus_in.dsack_n;
                berr_n_q  <= bus_in.berr_n;
            end
            case (state)
                S_IDLE: begin
                    if (phase.rising_plus_3)
                        mc_data_oe <= 1'b0;  // Write data hold ends.
                    if (!req_valid)
                        req_taken <= 1'b0;
                    else if (!req_taken) begin
                        {fc, rw, size, addr, wdata} <= req;
                        rdata <= '0;
                        req_taken <= 1'b1;
                        state <= S_START;
                    end
                end
                S_START: if (phase.rising) begin  // S0.
                    mc_fc <= fc;
                    mc_addr <= addr;
                    mc_rw <= rw;
                    mc_data <= lane_data;
                    mc_data_oe <= 1'b0;
                    case (size)
                        pistorm_pkg::SZ_BYTE:  mc_size <= 2'b01;
                        pistorm_pkg::SZ_WORD:  mc_size <= 2'b10;
                        pistorm_pkg::SZ_3BYTE: mc_size <= 2'b11;
                        default:               mc_size <= 2'b00;
                    endcase
                    state <= S_ASSERT_AS;
                end
                S_ASSERT_AS: if (phase.falling) begin  // S1.
                    mc_as <= 1'b1;
                    mc_ds <= rw;
                    state <= S_OPEN_DATA;
                end
                S_OPEN_DATA: if (phase.rising_plus_1) begin  // S2.
                    mc_data_oe <= !rw;
                    state <= S_WAIT_TERM;
                end
                S_WAIT_TERM: begin
                    if (phase.falling && !rw)
                        mc_ds <= 1'b1;
                    if (phase.falling_plus_1 && any_term)
                        state <= S_LATCH_DATA;
                end
                S_LATCH_DATA: if (phase.falling) begin  // S5, data sampled here.
                    mc_as <= 1'b0;
                    mc_ds <= 1'b0;
                    state <= rw ? S_UPDATE_READ : S_FINISH;
                end
                S_UPDATE_READ: begin
                    rdata <= read_merged;
                    state <= S_FINISH;
                end
                default: begin
                    if (!berr_n_q || size <= transferred) begin
                        term_q <= berr_n_q;
                        done <= 1'b1;
                        state <= S_IDLE;
                    end else begin
                        // Port was narrower than the rest of the operand.
                        addr <= addr + 24'(transferred) + 24'd1;
                        size <= size - transferred - 2'd1;
                        state <= S_START;
                    end
                end
            endcase
        end
    end

    assign bus_out = '{fc: mc_fc, addr: mc_addr, size: mc_size, rw: mc_rw, as: mc_as,
                       ds: mc_ds, data_oe: mc_data_oe, data: mc_data};
    assign result = '{rdata: rdata, terminated_normally: term_q, done: done};

endmodule

// ==== dyn_sizer.sv ====
// ========================================
// Dynamic bus sizing, pure combinational.
// Operand bytes are right-aligned in the data words.
// ========================================
module dyn_sizer (
    input  logic [1:0]               addr_lo,
    input  pistorm_pkg::op_size_t    size,
    input  pistorm_pkg::port_width_t width,
    input  logic [31:0]              write_data,
    input  logic [31:0]              bus_data,
    input  logic [31:0]              read_partial,
    output logic [31:0]              lane_data,
    output logic [31:0]              read_merged,
    output pistorm_pkg::op_size_t    transferred
);

    logic [7:0] b0, b1, b2, b3;  // b0 is the most significant byte.
    logic [1:0] shift;

    assign {b0, b1, b2, b3} = write_data;
    assign shift = addr_lo & width;
    assign transferred = width - shift;

    // Write lane replication, 68020 table 5-5.
    always_comb begin
        case (size)
            pistorm_pkg::SZ_BYTE: lane_data = {b3, b3, b3, b3};
            pistorm_pkg::SZ_WORD: begin
                if (addr_lo[0])
                    lane_data = {b2, b2, b3, b2};
                else
                    lane_data = {b2, b3, b2, b3};
            end
            pistorm_pkg::SZ_3BYTE: begin
                case (addr_lo)
                    2'd0: lane_data = {b1, b2, b3, 8'h00};
                    2'd1: lane_data = {b1, b1, b2, b3};
                    2'd2: lane_data = {b1, b2, b1, b2};
                    default: lane_data = {b1, b1, 8'h00, b1};
                endcase
            end
            default: begin // Long.
                case (addr_lo)
                    2'd0: lane_data = {b0, b1, b2, b3};
                    2'd1: lane_data = {b0, b0, b1, b2};
                    2'd2: lane_data = {b0, b1, b0, b1};
                    default: lane_data = {b0, b0, 8'h00, b0};
                endcase
            end
        endcase
    end

    // Read assembly, 68020 table 5-4.
    // Operand byte j takes the lane at shift + size - j when that lane exists.
    // Bytes past the port width are refilled by the following cycles.
    always_comb begin
        int lane;
        read_merged = read_partial;
        for (int j = 0; j < 4; j++) begin
            lane = int'(shift) + int'(size) - j;
            if (j <= int'(size) && lane <= 3)
                read_merged[8*j +: 8] = bus_data[8*(3 - lane) +: 8];
        end
    end

endmodule

// ==== pi_regs.sv ====
// ========================================
// pi_a and pi_d_in must hold for 4 clk after pi_wr falls.
// One request slot, a new ADDR_HI write waits for txn to drop.
// ========================================
module pi_regs (
    input  logic                        clk,
    input  logic                        reset,
    input  pistorm_pkg::pi_reg_e        pi_a,
    input  pistorm_pkg::pi_word_u       pi_d_in,
    input  logic                        pi_wr,
    input  logic                        pi_rd,
    input  pistorm_pkg::access_result_t result,
    output logic [15:0]                 pi_d_out,
    output logic                        pi_d_oe,
    output pistorm_pkg::access_req_t    req,
    output logic                        req_valid,
    output pistorm_pkg::ctrl_lines_t    ctrl
);

    logic [1:0]  wr_sync;
    logic        wr_commit;
    logic        done_d;
    logic        term_q;
    logic [14:0] ctrl_reg;

    assign wr_commit = wr_sync == 2'b10;  // Falling edge of pi_wr.

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_sync   <= 2'b11;
            req_valid <= 1'b0;
            done_d    <= 1'b0;
            term_q    <= 1'b0;
            ctrl_reg  <= '0;
        end else begin
            wr_sync <= {wr_sync[0], pi_wr};
            done_d  <= result.done;
            if (result.done)
                term_q <= result.terminated_normally;

            // Slot frees one clk after the done pulse.
            if (done_d)
                req_valid <= 1'b0;
            else if (wr_commit && pi_a == pistorm_pkg::REG_ADDR_HI)
                req_valid <= 1'b1;

            if (wr_commit && pi_a == pistorm_pkg::REG_STATUS) begin
                if (pi_d_in.control.set)
                    ctrl_reg <= ctrl_reg | pi_d_in.control.mask;
                else
                    ctrl_reg <= ctrl_reg & ~pi_d_in.control.mask;
            end
        end
    end

    // The data word doubles as the read-back of the last read access.
    always_ff @(posedge clk) begin
        if (result.done && req.rw)
            req.wdata <= result.rdata;
        if (wr_commit) begin
            case (pi_a)
                pistorm_pkg::REG_DATA_LO: req.wdata[15:0] <= pi_d_in;
                pistorm_pkg::REG_DATA_HI: req.wdata[31:16] <= pi_d_in;
                pistorm_pkg::REG_ADDR_LO: req.addr[15:0] <= pi_d_in;
                pistorm_pkg::REG_ADDR_HI: begin
                    req.addr[23:16] <= pi_d_in.addr_hi.addr;
                    req.size        <= pi_d_in.addr_hi.size;
                    req.rw          <= pi_d_in.addr_hi.rw;
                    req.fc          <= pi_d_in.addr_hi.fc;
                end
                default: ;
            endcase
        end
    end

    assign ctrl    = pistorm_pkg::ctrl_lines_t'(ctrl_reg[4:0]);
    assign pi_d_oe = !pi_rd && pi_wr;

    always_comb begin
        case (pi_a)
            pistorm_pkg::REG_DATA_LO: pi_d_out = req.wdata[15:0];
            pistorm_pkg::REG_DATA_HI: pi_d_out = req.wdata[31:16];
            pistorm_pkg::REG_ADDR_LO: pi_d_out = req.addr[15:0];
            pistorm_pkg::REG_ADDR_HI:
                pi_d_out = {2'b00, req.fc, req.rw, req.size, req.addr[23:16]};
            pistorm_pkg::REG_STATUS: pi_d_out = {14'd0, term_q, req_valid};
            default: pi_d_out = 16'h0000;
        endcase
    end

endmodule

// ==== bus_phase_gen.sv ====
// ========================================
// PLL_MULT must be even and at least 8.
// mc_clk must be a clean divide of clk.
// ========================================
module bus_phase_gen #(
    parameter int PLL_MULT = 12
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                mc_clk,
    output pistorm_pkg::phase_t phase
);

    localparam int CNT_W = $clog2(PLL_MULT);

    localparam logic [CNT_W-1:0] POS_FALL    = CNT_W'(PLL_MULT / 2 - 2);
    localparam logic [CNT_W-1:0] POS_FALL_P1 = CNT_W'(PLL_MULT / 2 - 1);
    localparam logic [CNT_W-1:0] POS_RISE    = CNT_W'(PLL_MULT - 2);
    localparam logic [CNT_W-1:0] POS_RISE_P1 = CNT_W'(PLL_MULT - 1);
    localparam logic [CNT_W-1:0] POS_RISE_P3 = CNT_W'((PLL_MULT + 1) % PLL_MULT);

    logic [1:0]       mc_clk_sync;  // Bit 1 is the older sample.
    logic [CNT_W-1:0] phase_cnt;

    always_ff @(posedge clk) begin
        mc_clk_sync <= {mc_clk_sync[0], mc_clk};
        if (reset)
            phase_cnt <= '0;
        else if (mc_clk_sync == 2'b01 || phase_cnt == POS_RISE_P1)
            phase_cnt <= '0;  // Realign on each MC_CLK rise.
        else
            phase_cnt <= phase_cnt + 1'b1;
    end

    assign phase.falling        = phase_cnt == POS_FALL;
    assign phase.falling_plus_1 = phase_cnt == POS_FALL_P1;
    assign phase.rising         = phase_cnt == POS_RISE;
    assign phase.rising_plus_1  = phase_cnt == POS_RISE_P1;
    assign phase.rising_plus_3  = phase_cnt == POS_RISE_P3;

endmodule

// ==== pistorm_pkg.sv ====
// ========================================
// Shared types for the Pi to MC68EC020 bridge.
// Bus strobes in the structs are active high.
// ========================================
package pistorm_pkg;

    // Operand size, byte count minus one.
    typedef logic [1:0] op_size_t;
    localparam op_size_t SZ_BYTE  = 2'd0;
    localparam op_size_t SZ_WORD  = 2'd1;
    localparam op_size_t SZ_3BYTE = 2'd2;
    localparam op_size_t SZ_LONG  = 2'd3;

    // Port width as decoded from DSACK.
    typedef logic [1:0] port_width_t;
    localparam port_width_t PW_8  = 2'd0;
    localparam port_width_t PW_16 = 2'd1;
    localparam port_width_t PW_32 = 2'd3;

    typedef enum logic [2:0] {
        REG_DATA_LO = 3'd0,
        REG_DATA_HI = 3'd1,
        REG_ADDR_LO = 3'd2,
        REG_ADDR_HI = 3'd3,
        REG_STATUS  = 3'd4 // Control on write.
    } pi_reg_e;

    // Pi write word, seen as request fields or as a control update.
    typedef union packed {
        struct packed {
            logic [1:0] spare;
            logic [2:0] fc;
            logic       rw;    // 1 is read.
            op_size_t   size;
            logic [7:0] addr;  // Address bits 23:16.
        } addr_hi;
        struct packed {
            logic        set;  // 0 clears the masked bits.
            logic [14:0] mask;
        } control;
    } pi_word_u;

    typedef struct packed {
        logic [2:0]  fc;
        logic        rw;
        op_size_t    size;
        logic [23:0] addr;
        logic [31:0] wdata;
    } access_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        terminated_normally;
        logic        done;  // One clk per access.
    } access_result_t;

    // Open-drain enables, ordered as control bits 4 down to 0.
    typedef struct packed {
        logic int6;
        logic int2;
        logic halt;
        logic reset;
        logic br;
    } ctrl_lines_t;

    typedef struct packed {
        logic [2:0]  fc;
        logic [23:0] addr;
        logic [1:0]  size;  // 68020 SIZE pins.
        logic        rw;
        logic        as;
        logic        ds;
        logic        data_oe;
        logic [31:0] data;
    } mc_bus_out_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  dsack_n;
        logic        berr_n;
    } mc_bus_in_t;

    typedef struct packed {
        logic falling;
        logic falling_plus_1;
        logic rising;
        logic rising_plus_1;
        logic rising_plus_3;
    } phase_t;

endpackage
